/* source/lc4_macros.svh */
`ifndef LC4_MACROS_SVH
`define LC4_MACROS_SVH

// datapath and address width
`define LC4_WORD_W 16

// register file geometry
`define LC4_NUM_REGS 8
`define LC4_REG_SEL_W 3

// opcode field at the top of the instruction word
`define LC4_OPCODE_W 4

// first fetch address out of reset
`define LC4_RESET_PC 16'h8200

`endif

/* source/lc4_isa_pkg.sv */
`include "lc4_macros.svh"

package lc4_isa_pkg;

    // only the opcodes this core executes, everything else decodes as a NOP
    typedef enum logic [`LC4_OPCODE_W-1:0] {
        OP_BR    = 4'b0000,
        OP_ADD   = 4'b0001,
        OP_AND   = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_ADDI,
        ALU_CONST,
        ALU_MEMADDR,
        ALU_BRTARGET
    } alu_op_t;

    typedef struct packed {
        logic n;
        logic z;
        logic p;
    } nzp_t;

    typedef struct packed {
        logic [`LC4_REG_SEL_W-1:0] r1sel;
        logic [`LC4_REG_SEL_W-1:0] r2sel;
        logic                      r1re;
        logic                      r2re;
        logic [`LC4_REG_SEL_W-1:0] wsel;
        logic                      regfile_we;
        logic                      nzp_we;
        logic                      is_load;
        logic                      is_store;
        logic                      is_branch;
        alu_op_t                   alu_op;
    } ctrl_t;

    // condition code of a 16-bit two's complement value
    function automatic nzp_t nzp_of(input logic [`LC4_WORD_W-1:0] value);
        nzp_t bits;
        bits.n = value[`LC4_WORD_W-1];
        bits.z = (value == '0);
        bits.p = !value[`LC4_WORD_W-1] && (value != '0);
        return bits;
    endfunction

endpackage

/* source/lc4_pipe_pkg.sv */
`include "lc4_macros.svh"

package lc4_pipe_pkg;
    import lc4_isa_pkg::*;

    // code 1 is reserved
    typedef enum logic [1:0] {
        NONE  = 2'd0,
        FLUSH = 2'd2,
        LOAD  = 2'd3
    } stall_t;

    // record that travels D -> X -> M -> W
    typedef struct packed {
        logic [`LC4_WORD_W-1:0] pc;
        logic [`LC4_WORD_W-1:0] insn;
        ctrl_t                  ctrl;
        stall_t                 stall;
    } stage_t;

    typedef enum logic [1:0] {
        REGFILE,
        FROM_M,
        FROM_W
    } fwd_t;

    typedef struct packed {
        stall_t                    stall;
        logic [`LC4_WORD_W-1:0]    pc;
        logic [`LC4_WORD_W-1:0]    insn;
        logic                      regfile_we;
        logic [`LC4_REG_SEL_W-1:0] regfile_wsel;
        logic [`LC4_WORD_W-1:0]    regfile_data;
        logic                      nzp_we;
        nzp_t                      nzp_bits;
        logic                      dmem_we;
        logic [`LC4_WORD_W-1:0]    dmem_addr;
        logic [`LC4_WORD_W-1:0]    dmem_data;
    } retire_t;

    // empty record tagged with why the slot is empty
    function automatic stage_t bubble(input stall_t code);
        stage_t rec;
        rec = '0;
        rec.stall = code;
        return rec;
    endfunction

endpackage

/* source/lc4_fetch.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_fetch (
    input  logic                   gwe,
    input  logic                   i_rst,
    input  logic [`LC4_WORD_W-1:0] i_insn,
    input  logic                   i_load_stall,
    input  logic                   i_br_taken,
    input  logic [`LC4_WORD_W-1:0] i_br_target,
    output logic [`LC4_WORD_W-1:0] o_pc,
    output logic [`LC4_WORD_W-1:0] o_d_pc,
    output logic [`LC4_WORD_W-1:0] o_d_insn
);

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            o_pc     <= `LC4_RESET_PC;
            o_d_pc   <= '0;
            o_d_insn <= '0;
        end else if (i_br_taken) begin
            // redirect and squash whatever was fetched down the wrong path
            o_pc     <= i_br_target;
            o_d_pc   <= '0;
            o_d_insn <= '0;
        end else if (!i_load_stall) begin
            o_pc     <= o_pc + 1'b1;
            o_d_pc   <= o_pc;
            o_d_insn <= i_insn;
        end
        // on a load-use stall F and D keep their contents
    end

endmodule

/* source/lc4_decoder.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_decoder
    import lc4_isa_pkg::*;
(
    input  logic [`LC4_WORD_W-1:0] i_insn,
    output ctrl_t                  o_ctrl
);

    opcode_t opcode;
    logic    writes;

    assign opcode = opcode_t'(i_insn[`LC4_WORD_W-1 -: `LC4_OPCODE_W]);

    always_comb begin
        o_ctrl        = '0;
        o_ctrl.r1sel  = i_insn[8:6];
        o_ctrl.r2sel  = i_insn[2:0];
        o_ctrl.wsel   = i_insn[11:9];
        o_ctrl.alu_op = ALU_ADD;
        writes        = 1'b0;
        case (opcode)
            OP_BR: begin
                // empty mask is the NOP
                if (i_insn[11:9] != 3'b000) begin
                    o_ctrl.is_branch = 1'b1;
                    o_ctrl.alu_op    = ALU_BRTARGET;
                end
            end
            OP_ADD: begin
                // ADD, SUB and the imm5 form, MUL and DIV fall through as NOPs
                writes        = i_insn[5] || (i_insn[5:3] == 3'b000) || (i_insn[5:3] == 3'b010);
                o_ctrl.r1re   = writes;
                o_ctrl.r2re   = writes && !i_insn[5];
                o_ctrl.alu_op = i_insn[5] ? ALU_ADDI : (i_insn[4] ? ALU_SUB : ALU_ADD);
            end
            OP_AND: begin
                writes        = (i_insn[5:3] == 3'b000) || (i_insn[5:3] == 3'b010);
                o_ctrl.r1re   = writes;
                o_ctrl.r2re   = writes;
                o_ctrl.alu_op = i_insn[4] ? ALU_OR : ALU_AND;
            end
            OP_LDR: begin
                writes         = 1'b1;
                o_ctrl.r1re    = 1'b1;
                o_ctrl.is_load = 1'b1;
                o_ctrl.alu_op  = ALU_MEMADDR;
            end
            OP_STR: begin
                // store data register sits in the rd field
                o_ctrl.r2sel    = i_insn[11:9];
                o_ctrl.r1re     = 1'b1;
                o_ctrl.r2re     = 1'b1;
                o_ctrl.is_store = 1'b1;
                o_ctrl.alu_op   = ALU_MEMADDR;
            end
            OP_CONST: begin
                writes        = 1'b1;
                o_ctrl.alu_op = ALU_CONST;
            end
            default: begin
                writes = 1'b0;
            end
        endcase
        // every register writer also sets the condition codes
        o_ctrl.regfile_we = writes;
        o_ctrl.nzp_we     = writes;
    end

endmodule

/* source/lc4_regfile.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_regfile (
    input  logic                      gwe,
    input  logic                      i_rst,
    input  logic [`LC4_REG_SEL_W-1:0] i_rs_sel,
    input  logic [`LC4_REG_SEL_W-1:0] i_rt_sel,
    input  logic [`LC4_REG_SEL_W-1:0] i_wsel,
    input  logic                      i_we,
    input  logic [`LC4_WORD_W-1:0]    i_wdata,
    output logic [`LC4_WORD_W-1:0]    o_rs_data,
    output logic [`LC4_WORD_W-1:0]    o_rt_data
);

    logic [`LC4_WORD_W-1:0] regs [`LC4_NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < `LC4_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_wsel] <= i_wdata;
        end
    end

    // W-stage write is seen by the D-stage read in the same cycle
    assign o_rs_data = (i_we && (i_wsel == i_rs_sel)) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_we && (i_wsel == i_rt_sel)) ? i_wdata : regs[i_rt_sel];

endmodule

/* source/lc4_hazard_unit.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_hazard_unit
    import lc4_isa_pkg::*, lc4_pipe_pkg::*;
(
    input  ctrl_t i_d_ctrl,
    input  ctrl_t i_x_ctrl,
    input  ctrl_t i_m_ctrl,
    input  ctrl_t i_w_ctrl,
    output logic  o_load_stall,
    output fwd_t  o_fwd_rs,
    output fwd_t  o_fwd_rt,
    output logic  o_store_fwd
);

    logic rs_dep;
    logic rt_dep;

    // M is younger than W, so it wins when both write the register
    function automatic fwd_t pick_src(input logic re,
                                      input logic [`LC4_REG_SEL_W-1:0] sel,
                                      input ctrl_t m,
                                      input ctrl_t w);
        if (re && m.regfile_we && (m.wsel == sel))
            return FROM_M;
        if (re && w.regfile_we && (w.wsel == sel))
            return FROM_W;
        return REGFILE;
    endfunction

    assign rs_dep = i_d_ctrl.r1re && (i_d_ctrl.r1sel == i_x_ctrl.wsel);
    // store data gets patched later in M from W, no bubble needed
    assign rt_dep = i_d_ctrl.r2re && !i_d_ctrl.is_store && (i_d_ctrl.r2sel == i_x_ctrl.wsel);

    // a branch needs the load's nzp, which only exists once the load is in M
    assign o_load_stall = i_x_ctrl.is_load && (rs_dep || rt_dep || i_d_ctrl.is_branch);

    assign o_fwd_rs = pick_src(i_x_ctrl.r1re, i_x_ctrl.r1sel, i_m_ctrl, i_w_ctrl);
    assign o_fwd_rt = pick_src(i_x_ctrl.r2re, i_x_ctrl.r2sel, i_m_ctrl, i_w_ctrl);

    assign o_store_fwd = i_m_ctrl.is_store && i_w_ctrl.regfile_we &&
                         (i_w_ctrl.wsel == i_m_ctrl.r2sel);

endmodule

/* source/lc4_alu.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_alu
    import lc4_isa_pkg::*;
(
    input  alu_op_t                i_op,
    input  logic [`LC4_WORD_W-1:0] i_pc,
    input  logic [`LC4_WORD_W-1:0] i_rs,
    input  logic [`LC4_WORD_W-1:0] i_rt,
    input  logic [`LC4_WORD_W-1:0] i_insn,
    output logic [`LC4_WORD_W-1:0] o_result
);

    logic [`LC4_WORD_W-1:0] imm5;
    logic [`LC4_WORD_W-1:0] imm6;
    logic [`LC4_WORD_W-1:0] imm9;

    // sign-extended immediates
    assign imm5 = {{(`LC4_WORD_W-5){i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{(`LC4_WORD_W-6){i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{(`LC4_WORD_W-9){i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        case (i_op)
            ALU_ADD:      o_result = i_rs + i_rt;
            ALU_SUB:      o_result = i_rs - i_rt;
            ALU_AND:      o_result = i_rs & i_rt;
            ALU_OR:       o_result = i_rs | i_rt;
            ALU_ADDI:     o_result = i_rs + imm5;
            ALU_CONST:    o_result = imm9;
            ALU_MEMADDR:  o_result = i_rs + imm6;
            // target is relative to the next sequential pc
            ALU_BRTARGET: o_result = i_pc + imm9 + 1'b1;
            default:      o_result = '0;
        endcase
    end

endmodule

/* source/lc4_execute.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_execute
    import lc4_isa_pkg::*, lc4_pipe_pkg::*;
(
    input  logic                   gwe,
    input  logic                   i_rst,
    input  logic [`LC4_WORD_W-1:0] i_d_pc,
    input  logic [`LC4_WORD_W-1:0] i_d_insn,
    input  ctrl_t                  i_d_ctrl,
    input  logic [`LC4_WORD_W-1:0] i_rs_data,
    input  logic [`LC4_WORD_W-1:0] i_rt_data,
    input  logic                   i_load_stall,
    input  fwd_t                   i_fwd_rs,
    input  fwd_t                   i_fwd_rt,
    input  logic [`LC4_WORD_W-1:0] i_m_result,
    input  logic [`LC4_WORD_W-1:0] i_wb_data,
    input  nzp_t                   i_load_nzp,
    input  logic                   i_m_is_load,
    output stage_t                 o_x_stage,
    output logic [`LC4_WORD_W-1:0] o_x_result,
    output logic [`LC4_WORD_W-1:0] o_x_rt_value,
    output logic                   o_br_taken,
    output logic [`LC4_WORD_W-1:0] o_br_target
);

    // D holds the NOP left behind by reset or a taken branch
    logic                   d_flushed;
    logic [`LC4_WORD_W-1:0] x_rs_q;
    logic [`LC4_WORD_W-1:0] x_rt_q;
    logic [`LC4_WORD_W-1:0] rs_val;
    nzp_t                   nzp_q;

    function automatic logic [`LC4_WORD_W-1:0] bypass(input fwd_t src,
                                                      input logic [`LC4_WORD_W-1:0] rf_val,
                                                      input logic [`LC4_WORD_W-1:0] m_val,
                                                      input logic [`LC4_WORD_W-1:0] w_val);
        case (src)
            FROM_M:  return m_val;
            FROM_W:  return w_val;
            default: return rf_val;
        endcase
    endfunction

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            o_x_stage <= bubble(FLUSH);
            d_flushed <= 1'b1;
        end else begin
            d_flushed <= o_br_taken;
            if (o_br_taken) begin
                o_x_stage <= bubble(FLUSH);
            end else if (i_load_stall) begin
                o_x_stage <= bubble(LOAD);
            end else begin
                o_x_stage <= '{pc: i_d_pc, insn: i_d_insn, ctrl: i_d_ctrl,
                               stall: d_flushed ? FLUSH : NONE};
            end
        end
    end

    always_ff @(posedge gwe) begin
        x_rs_q <= i_rs_data;
        x_rt_q <= i_rt_data;
    end

    assign rs_val       = bypass(i_fwd_rs, x_rs_q, i_m_result, i_wb_data);
    assign o_x_rt_value = bypass(i_fwd_rt, x_rt_q, i_m_result, i_wb_data);

    lc4_alu u_alu (
        .i_op     (o_x_stage.ctrl.alu_op),
        .i_pc     (o_x_stage.pc),
        .i_rs     (rs_val),
        .i_rt     (o_x_rt_value),
        .i_insn   (o_x_stage.insn),
        .o_result (o_x_result)
    );

    // younger ALU result beats an older load finishing in M on the same edge
    always_ff @(posedge gwe) begin
        if (i_rst)
            nzp_q <= nzp_t'(3'b010);
        else if (o_x_stage.ctrl.nzp_we && !o_x_stage.ctrl.is_load)
            nzp_q <= nzp_of(o_x_result);
        else if (i_m_is_load)
            nzp_q <= i_load_nzp;
    end

    assign o_br_taken  = o_x_stage.ctrl.is_branch && |(nzp_q & o_x_stage.insn[11:9]);
    assign o_br_target = o_x_result;

endmodule

/* source/lc4_mem_wb.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_mem_wb
    import lc4_isa_pkg::*, lc4_pipe_pkg::*;
(
    input  logic                      gwe,
    input  logic                      i_rst,
    input  stage_t                    i_x_stage,
    input  logic [`LC4_WORD_W-1:0]    i_x_result,
    input  logic [`LC4_WORD_W-1:0]    i_x_rt_value,
    input  logic                      i_store_fwd,
    input  logic [`LC4_WORD_W-1:0]    i_dmem_rdata,
    output logic [`LC4_WORD_W-1:0]    o_dmem_addr,
    output logic                      o_dmem_we,
    output logic [`LC4_WORD_W-1:0]    o_dmem_towrite,
    output logic [`LC4_WORD_W-1:0]    o_m_result,
    output ctrl_t                     o_m_ctrl,
    output ctrl_t                     o_w_ctrl,
    output nzp_t                      o_load_nzp,
    output logic                      o_wb_we,
    output logic [`LC4_REG_SEL_W-1:0] o_wb_wsel,
    output logic [`LC4_WORD_W-1:0]    o_wb_data,
    output retire_t                   o_retire
);

    stage_t                 m_stage;
    stage_t                 w_stage;
    logic [`LC4_WORD_W-1:0] m_rt_q;
    logic [`LC4_WORD_W-1:0] w_result_q;
    logic [`LC4_WORD_W-1:0] w_addr_q;
    // loaded word for a load, stored word for a store, zero otherwise
    logic [`LC4_WORD_W-1:0] w_mem_q;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            m_stage <= bubble(FLUSH);
            w_stage <= bubble(FLUSH);
        end else begin
            m_stage <= i_x_stage;
            w_stage <= m_stage;
        end
    end

    always_ff @(posedge gwe) begin
        o_m_result <= i_x_result;
        m_rt_q     <= i_x_rt_value;
        w_result_q <= o_m_result;
        w_addr_q   <= o_dmem_addr;
        w_mem_q    <= m_stage.ctrl.is_load ? i_dmem_rdata : o_dmem_towrite;
    end

    assign o_dmem_addr = (m_stage.ctrl.is_load || m_stage.ctrl.is_store) ? o_m_result : '0;
    assign o_dmem_we   = m_stage.ctrl.is_store;
    // W holds the instruction just ahead of the store, so its value is the newest
    assign o_dmem_towrite = !m_stage.ctrl.is_store ? '0 :
                            i_store_fwd ? o_wb_data : m_rt_q;
    assign o_load_nzp = m_stage.ctrl.is_load ? nzp_of(i_dmem_rdata) : '0;

    assign o_m_ctrl  = m_stage.ctrl;
    assign o_w_ctrl  = w_stage.ctrl;
    assign o_wb_we   = w_stage.ctrl.regfile_we;
    assign o_wb_wsel = w_stage.ctrl.wsel;
    assign o_wb_data = w_stage.ctrl.is_load ? w_mem_q : w_result_q;

    always_comb begin
        o_retire.stall        = w_stage.stall;
        o_retire.pc           = w_stage.pc;
        o_retire.insn         = w_stage.insn;
        o_retire.regfile_we   = o_wb_we;
        o_retire.regfile_wsel = o_wb_wsel;
        o_retire.regfile_data = o_wb_data;
        o_retire.nzp_we       = w_stage.ctrl.nzp_we;
        o_retire.nzp_bits     = nzp_of(o_wb_data);
        o_retire.dmem_we      = w_stage.ctrl.is_store;
        o_retire.dmem_addr    = w_addr_q;
        o_retire.dmem_data    = w_mem_q;
    end

endmodule

/* source/lc4_processor.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_processor
    import lc4_isa_pkg::*, lc4_pipe_pkg::*;
(
    input  logic                   gwe,
    input  logic                   i_rst,
    output logic [`LC4_WORD_W-1:0] o_pc,
    input  logic [`LC4_WORD_W-1:0] i_insn,
    output logic [`LC4_WORD_W-1:0] o_dmem_addr,
    output logic                   o_dmem_we,
    output logic [`LC4_WORD_W-1:0] o_dmem_towrite,
    input  logic [`LC4_WORD_W-1:0] i_dmem_rdata,
    output retire_t                o_retire
);

    logic [`LC4_WORD_W-1:0]    d_pc;
    logic [`LC4_WORD_W-1:0]    d_insn;
    ctrl_t                     d_ctrl;
    logic [`LC4_WORD_W-1:0]    rs_data;
    logic [`LC4_WORD_W-1:0]    rt_data;
    logic                      load_stall;
    fwd_t                      fwd_rs;
    fwd_t                      fwd_rt;
    logic                      store_fwd;
    stage_t                    x_stage;
    logic [`LC4_WORD_W-1:0]    x_result;
    logic [`LC4_WORD_W-1:0]    x_rt_value;
    logic                      br_taken;
    logic [`LC4_WORD_W-1:0]    br_target;
    logic [`LC4_WORD_W-1:0]    m_result;
    ctrl_t                     m_ctrl;
    ctrl_t                     w_ctrl;
    nzp_t                      load_nzp;
    logic                      wb_we;
    logic [`LC4_REG_SEL_W-1:0] wb_wsel;
    logic [`LC4_WORD_W-1:0]    wb_data;

    lc4_fetch u_fetch (
        .gwe (gwe), .i_rst (i_rst),
        .i_insn       (i_insn),
        .i_load_stall (load_stall),
        .i_br_taken   (br_taken),
        .i_br_target  (br_target),
        .o_pc         (o_pc),
        .o_d_pc       (d_pc),
        .o_d_insn     (d_insn)
    );

    lc4_decoder u_decoder (
        .i_insn (d_insn),
        .o_ctrl (d_ctrl)
    );

    lc4_regfile u_regfile (
        .gwe (gwe), .i_rst (i_rst),
        .i_rs_sel  (d_ctrl.r1sel),
        .i_rt_sel  (d_ctrl.r2sel),
        .i_wsel    (wb_wsel),
        .i_we      (wb_we),
        .i_wdata   (wb_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    lc4_hazard_unit u_hazard (
        .i_d_ctrl     (d_ctrl),
        .i_x_ctrl     (x_stage.ctrl),
        .i_m_ctrl     (m_ctrl),
        .i_w_ctrl     (w_ctrl),
        .o_load_stall (load_stall),
        .o_fwd_rs     (fwd_rs),
        .o_fwd_rt     (fwd_rt),
        .o_store_fwd  (store_fwd)
    );

    lc4_execute u_execute (
        .gwe (gwe), .i_rst (i_rst),
        .i_d_pc (d_pc), .i_d_insn (d_insn), .i_d_ctrl (d_ctrl),
        .i_rs_data (rs_data), .i_rt_data (rt_data),
        .i_load_stall (load_stall),
        .i_fwd_rs (fwd_rs), .i_fwd_rt (fwd_rt),
        .i_m_result (m_result), .i_wb_data (wb_data),
        .i_load_nzp (load_nzp), .i_m_is_load (m_ctrl.is_load),
        .o_x_stage (x_stage), .o_x_result (x_result), .o_x_rt_value (x_rt_value),
        .o_br_taken (br_taken), .o_br_target (br_target)
    );

    lc4_mem_wb u_mem_wb (
        .gwe (gwe), .i_rst (i_rst),
        .i_x_stage (x_stage), .i_x_result (x_result), .i_x_rt_value (x_rt_value),
        .i_store_fwd (store_fwd), .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_addr (o_dmem_addr), .o_dmem_we (o_dmem_we),
        .o_dmem_towrite (o_dmem_towrite),
        .o_m_result (m_result), .o_m_ctrl (m_ctrl), .o_w_ctrl (w_ctrl),
        .o_load_nzp (load_nzp),
        .o_wb_we (wb_we), .o_wb_wsel (wb_wsel), .o_wb_data (wb_data),
        .o_retire (o_retire)
    );

endmodule

/* sim/tb_lc4_processor.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module tb_lc4_processor
    import lc4_pipe_pkg::*;
();

    localparam int RAND_COUNT = 200;
    localparam int CLK_NS     = 4;
    localparam int DRIVE_NS   = 1;

    logic                   gwe;
    logic                   i_rst;
    logic [`LC4_WORD_W-1:0] o_pc;
    logic [`LC4_WORD_W-1:0] i_insn;
    logic [`LC4_WORD_W-1:0] o_dmem_addr;
    logic                   o_dmem_we;
    logic [`LC4_WORD_W-1:0] o_dmem_towrite;
    logic [`LC4_WORD_W-1:0] i_dmem_rdata;
    retire_t                retire;

    logic [15:0] imem [65536];
    logic [15:0] dmem [65536];
    // reference copies kept in program order
    logic [15:0] model_mem [65536];
    logic [15:0] model_regs [8];
    logic [2:0]  model_nzp;
    logic [15:0] exp_pc;
    logic [15:0] prog_end;
    logic [31:0] rng;
    int          watch_ns;
    bit          started;
    bit          run_done;
    bit          prev_taken;
    bit          prev_load;
    logic [2:0]  prev_rd;
    int          seen_flush;
    int          seen_load;
    int          n_taken;
    int          n_not_taken;
    int          n_load_stall;
    int          n_store;

    lc4_processor u_dut (
        .gwe            (gwe),
        .i_rst          (i_rst),
        .o_pc           (o_pc),
        .i_insn         (i_insn),
        .o_dmem_addr    (o_dmem_addr),
        .o_dmem_we      (o_dmem_we),
        .o_dmem_towrite (o_dmem_towrite),
        .i_dmem_rdata   (i_dmem_rdata),
        .o_retire       (retire)
    );

    always #(CLK_NS / 2) gwe = ~gwe;

    // both memories answer combinationally, refreshed just after each edge
    always @(posedge gwe) begin
        #(DRIVE_NS);
        i_insn       = imem[o_pc];
        i_dmem_rdata = dmem[o_dmem_addr];
    end

    always @(negedge gwe) begin
        if (o_dmem_we === 1'b1)
            dmem[o_dmem_addr] = o_dmem_towrite;
    end

    always @(negedge gwe) begin
        if (!i_rst && !run_done)
            check_retire();
    end

    function automatic logic [15:0] fill_word(input int addr);
        logic [31:0] mix;
        mix = addr * 32'h9e3779b1;
        return mix[31:16] ^ addr[15:0];
    endfunction

    function automatic logic [15:0] next_random();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng[31:16];
    endfunction

    function automatic logic [2:0] cond_code(input logic [15:0] v);
        return {v[15], v == 16'h0000, !v[15] && (v != 16'h0000)};
    endfunction

    // operands that must be ready in X, store data excluded
    function automatic bit reads_reg(input logic [15:0] insn, input logic [2:0] r);
        case (insn[15:12])
            4'b0000: return insn[11:9] != 3'b000;
            4'b0001: return (insn[8:6] == r) || (!insn[5] && (insn[2:0] == r));
            4'b0101: return (insn[8:6] == r) || (insn[2:0] == r);
            4'b0110, 4'b0111: return insn[8:6] == r;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [15:0] enc_rrr(input logic [3:0] op, input logic [2:0] sub,
                                            input int rd, input int rs, input int rt);
        return {op, rd[2:0], rs[2:0], sub, rt[2:0]};
    endfunction

    function automatic logic [15:0] enc_addi(input int rd, input int rs, input int imm);
        return {4'b0001, rd[2:0], rs[2:0], 1'b1, imm[4:0]};
    endfunction

    function automatic logic [15:0] enc_const(input int rd, input int imm);
        return {4'b1001, rd[2:0], imm[8:0]};
    endfunction

    function automatic logic [15:0] enc_mem(input logic [3:0] op, input int r,
                                            input int rs, input int imm);
        return {op, r[2:0], rs[2:0], imm[5:0]};
    endfunction

    function automatic logic [15:0] enc_br(input int mask, input int imm);
        return {4'b0000, mask[2:0], imm[8:0]};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic expect_equal(input string what, input logic [15:0] got,
                                input logic [15:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run("DUT output differs from the reference model");
        end
    endtask

    task automatic emit(input logic [15:0] word);
        imem[prog_end] = word;
        prog_end = prog_end + 16'd1;
    endtask

    task automatic build_directed();
        // ALU chain, each step reading one or two back
        emit(enc_const(1, 5));
        emit(enc_const(2, -3));
        emit(enc_rrr(4'b0001, 3'b000, 3, 1, 2));
        emit(enc_rrr(4'b0001, 3'b010, 4, 3, 1));
        emit(enc_rrr(4'b0101, 3'b000, 5, 4, 3));
        emit(enc_rrr(4'b0101, 3'b010, 6, 5, 4));
        emit(enc_addi(7, 6, -1));
        emit(enc_rrr(4'b0001, 3'b000, 1, 7, 3));
        // load-use pairs
        emit(enc_const(0, 16));
        emit(enc_mem(4'b0110, 1, 0, 2));
        emit(enc_rrr(4'b0001, 3'b000, 2, 1, 1));
        emit(enc_mem(4'b0110, 3, 0, -1));
        emit(enc_addi(4, 3, 1));
        // store of a fresh value, read back
        emit(enc_addi(5, 2, 7));
        emit(enc_mem(4'b0111, 5, 0, 4));
        emit(enc_mem(4'b0110, 6, 0, 4));
        emit(enc_rrr(4'b0001, 3'b000, 7, 6, 0));
        // store data straight out of a load
        emit(enc_mem(4'b0110, 5, 0, 2));
        emit(enc_mem(4'b0111, 5, 0, 8));
        // taken, not taken, then branches behind loads
        emit(enc_const(1, -4));
        emit(enc_br(3'b100, 1));
        emit(enc_const(7, 99));
        emit(enc_br(3'b011, 1));
        emit(enc_const(2, 0));
        emit(enc_br(3'b010, 1));
        emit(enc_const(3, 1));
        emit(enc_mem(4'b0110, 4, 0, 2));
        emit(enc_br(3'b100, 1));
        emit(enc_const(6, 7));
        emit(enc_mem(4'b0110, 4, 0, 2));
        emit(enc_br(3'b011, 1));
        emit(enc_const(6, 9));
    endtask

    task automatic build_random();
        logic [15:0] r;
        logic [15:0] imm;
        int          mask;
        for (int i = 0; i < RAND_COUNT; i++) begin
            r    = next_random();
            imm  = next_random();
            mask = (r[14:12] == 3'b000) ? 7 : r[14:12];
            case (r[11:9])
                3'd0: emit(enc_rrr(4'b0001, r[12] ? 3'b010 : 3'b000, r[2:0], r[5:3], r[8:6]));
                3'd1: emit(enc_rrr(4'b0101, r[12] ? 3'b010 : 3'b000, r[2:0], r[5:3], r[8:6]));
                3'd2: emit(enc_addi(r[2:0], r[5:3], imm));
                3'd3: emit(enc_const(r[2:0], imm));
                3'd4: emit(enc_mem(4'b0110, r[2:0], r[5:3], imm));
                3'd5: emit(enc_mem(4'b0111, r[2:0], r[5:3], imm));
                // forward only, so the program always runs off its end
                3'd6: emit(enc_br(mask, imm[1:0]));
                default: emit(enc_rrr(4'b0001, 3'b000, r[2:0], r[5:3], r[8:6]));
            endcase
        end
    endtask

    task automatic check_retire();
        logic [15:0] insn;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic [15:0] addr;
        logic [15:0] mdata;
        logic [15:0] next_pc;
        logic [2:0]  rd;
        bit          wr;
        bit          st;
        bit          ld;
        bit          taken;
        if (retire.stall != NONE) begin
            assert (!retire.regfile_we && !retire.nzp_we && !retire.dmem_we) else
                stop_run("a bubble record on the retire trace has a write enable set");
            if (!started)
                expect_equal("stall code before the first retire", retire.stall, FLUSH);
            else if (retire.stall == FLUSH)
                seen_flush++;
            else if (retire.stall == LOAD)
                seen_load++;
            else
                stop_run("reserved stall code seen on the retire trace");
        end else begin
            insn = imem[exp_pc];
            if (started) begin
                expect_equal("FLUSH records before retire", seen_flush, prev_taken ? 2 : 0);
                expect_equal("LOAD records before retire", seen_load,
                             (!prev_taken && prev_load && reads_reg(insn, prev_rd)) ? 1 : 0);
            end
            n_load_stall += seen_load;
            seen_flush = 0;
            seen_load  = 0;
            expect_equal("retire pc", retire.pc, exp_pc);
            expect_equal("retire insn", retire.insn, insn);

            rd      = insn[11:9];
            a       = model_regs[insn[8:6]];
            b       = model_regs[insn[2:0]];
            wr      = 1'b0;
            st      = 1'b0;
            ld      = 1'b0;
            taken   = 1'b0;
            res     = '0;
            addr    = '0;
            mdata   = '0;
            next_pc = exp_pc + 16'd1;
            case (insn[15:12])
                4'b0000: begin
                    taken = (insn[11:9] & model_nzp) != 3'b000;
                    if (taken)
                        next_pc = next_pc + {{7{insn[8]}}, insn[8:0]};
                    if (insn[11:9] != 3'b000) begin
                        if (taken)
                            n_taken++;
                        else
                            n_not_taken++;
                    end
                end
                4'b0001: begin
                    wr = 1'b1;
                    if (insn[5])
                        res = a + {{11{insn[4]}}, insn[4:0]};
                    else
                        res = insn[4] ? a - b : a + b;
                end
                4'b0101: begin
                    wr  = 1'b1;
                    res = insn[4] ? (a | b) : (a & b);
                end
                4'b0110: begin
                    wr    = 1'b1;
                    ld    = 1'b1;
                    addr  = a + {{10{insn[5]}}, insn[5:0]};
                    res   = model_mem[addr];
                    mdata = res;
                end
                4'b0111: begin
                    st    = 1'b1;
                    addr  = a + {{10{insn[5]}}, insn[5:0]};
                    mdata = model_regs[rd];
                    model_mem[addr] = mdata;
                    n_store++;
                end
                4'b1001: begin
                    wr  = 1'b1;
                    res = {{7{insn[8]}}, insn[8:0]};
                end
                default: begin
                    wr = 1'b0;
                end
            endcase

            expect_equal("regfile_we", retire.regfile_we, wr);
            expect_equal("nzp_we", retire.nzp_we, wr);
            if (wr) begin
                expect_equal("regfile_wsel", retire.regfile_wsel, rd);
                expect_equal("regfile_data", retire.regfile_data, res);
                expect_equal("nzp_bits", retire.nzp_bits, cond_code(res));
                model_regs[rd] = res;
                model_nzp      = cond_code(res);
            end
            expect_equal("dmem_we", retire.dmem_we, st);
            expect_equal("dmem_addr", retire.dmem_addr, addr);
            expect_equal("dmem_data", retire.dmem_data, mdata);

            prev_taken = taken;
            prev_load  = ld;
            prev_rd    = rd;
            started    = 1'b1;
            exp_pc     = next_pc;
            if (exp_pc >= prog_end)
                run_done = 1'b1;
        end
    endtask

    // watchdog sized from the program length, four cycles per instruction
    initial begin
        wait (watch_ns > 0);
        #(watch_ns);
        stop_run("timeout: the program did not finish retiring in time");
    end

    initial begin
        gwe          = 1'b0;
        i_rst        = 1'b1;
        i_insn       = '0;
        i_dmem_rdata = '0;
        for (int a = 0; a < 65536; a++) begin
            imem[a]      = 16'h0000;
            dmem[a]      = fill_word(a);
            model_mem[a] = dmem[a];
        end
        for (int r = 0; r < 8; r++) begin
            model_regs[r] = '0;
        end
        model_nzp = 3'b010;
        rng       = 32'd14;
        prog_end  = `LC4_RESET_PC;
        exp_pc    = `LC4_RESET_PC;
        build_directed();
        build_random();
        watch_ns = int'(prog_end - `LC4_RESET_PC) * 4 * CLK_NS + 8 * CLK_NS + 400;

        repeat (8) @(posedge gwe);
        #(DRIVE_NS);
        expect_equal("o_pc during reset", o_pc, `LC4_RESET_PC);
        i_rst = 1'b0;

        wait (run_done);
        @(posedge gwe);
        if (n_taken > 0 && n_not_taken > 0 && n_load_stall > 0 && n_store > 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_run("the program never reached a taken branch, load stall or store");
        end
    end

endmodule

/* src.f */
+incdir+source
source/lc4_isa_pkg.sv
source/lc4_pipe_pkg.sv
source/lc4_fetch.sv
source/lc4_decoder.sv
source/lc4_regfile.sv
source/lc4_hazard_unit.sv
source/lc4_alu.sv
source/lc4_execute.sv
source/lc4_mem_wb.sv
source/lc4_processor.sv
sim/tb_lc4_processor.sv
